// File: alc_pkg.sv
package alc_pkg;

	//////////////////////////////
	// Flash geometry and data path
	localparam int FLASH_ADDR_W = 23;
	localparam int DATA_W = 16;
	localparam int CNT_W = 6;
	localparam int CONST_COUNT = 34;
	// Last parameter block of the device
	localparam logic [FLASH_ADDR_W-1:0] PARAM_BLOCK_BASE = 23'h7FC000;
	localparam logic [DATA_W-1:0] READ_ARRAY_CMD = 16'h00FF;
	localparam int RD_TIMEOUT = 64;
	localparam int TMO_W = $clog2(RD_TIMEOUT + 1);
	localparam int CMD_CYCLES = 2;
	localparam int CMD_CNT_W = $clog2(CMD_CYCLES + 1);

	//////////////////////////////
	// Host register map
	localparam int AXI_ADDR_W = 8;
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h04;
	localparam logic [AXI_ADDR_W-1:0] REG_COUNT = 8'h08;
	localparam logic [AXI_ADDR_W-1:0] REG_CONST_BASE = 8'h40;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Status bit positions
	localparam int ST_RUNNING = 0;
	localparam int ST_COMPLETED = 1;
	localparam int ST_ABORTED = 2;

	typedef enum logic [1:0] {OP_NOP = 2'b00, OP_READ = 2'b10} bpi_op_e;
	typedef enum logic [2:0] {AL_IDLE, AL_ISSUE, AL_WAIT, AL_NEXT, AL_FINISH} al_state_e;

endpackage

// File: auto_load_fsm.sv
`timescale 1ns/10ps

module auto_load_fsm (
	input  logic CLK,
	input  logic RST,
	input  logic start,
	input  logic busy,
	input  logic rd_valid,
	output logic [alc_pkg::CNT_W-1:0] al_cnt,
	output logic execute,
	output logic al_ena,
	output logic completed,
	output logic aborted,
	output logic seq_abort
);
	import alc_pkg::*;

	al_state_e state;
	logic [TMO_W-1:0] tmo_cnt;
	logic timeout;

	// Read took too long while the sequencer still reports busy
	assign timeout = (state == AL_WAIT) && busy && !rd_valid
		&& (tmo_cnt == TMO_W'(RD_TIMEOUT - 1));

	// One cycle request, only when the sequencer is free
	assign execute = (state == AL_ISSUE) && !busy;
	assign completed = (state == AL_FINISH);
	assign aborted = timeout;
	// Same event, sent back to the sequencer to drop its operation
	assign seq_abort = timeout;

	//////////////////////////////
	// Load sequencing
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= AL_IDLE;
			al_cnt <= '0;
			al_ena <= 1'b0;
			tmo_cnt <= '0;
		end else begin
			case (state)
				AL_IDLE: begin
					if (start) begin
						state <= AL_ISSUE;
						al_cnt <= '0;
						al_ena <= 1'b1;
					end
				end
				AL_ISSUE: begin
					if (!busy) begin
						state <= AL_WAIT;
						tmo_cnt <= '0;
					end
				end
				AL_WAIT: begin
					if (rd_valid) begin
						state <= AL_NEXT;
					end else if (timeout) begin
						// Word counter stays on the failing word
						state <= AL_IDLE;
						al_ena <= 1'b0;
					end else if (busy) begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				AL_NEXT: begin
					al_cnt <= al_cnt + 1'b1;
					if (al_cnt == CNT_W'(CONST_COUNT - 1)) begin
						state <= AL_FINISH;
					end else begin
						state <= AL_ISSUE;
					end
				end
				AL_FINISH: begin
					state <= AL_IDLE;
					al_ena <= 1'b0;
				end
				default: begin
					state <= AL_IDLE;
					al_ena <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: auto_load_const.sv
`timescale 1ns/10ps

module auto_load_const (
	input  logic CLK,
	input  logic RST,
	input  logic start,
	input  logic busy,
	input  logic rd_valid,
	input  logic [alc_pkg::DATA_W-1:0] rd_data,
	input  logic [alc_pkg::CNT_W-1:0] const_idx,
	output logic [alc_pkg::FLASH_ADDR_W-1:0] al_addr,
	output logic [alc_pkg::DATA_W-1:0] al_cmd_data,
	output alc_pkg::bpi_op_e al_op,
	output logic execute,
	output logic seq_abort,
	output logic [2:0] al_status,
	output logic [alc_pkg::CNT_W-1:0] al_cnt,
	output logic [alc_pkg::DATA_W-1:0] const_data
);
	import alc_pkg::*;

	logic al_ena;
	logic completed;
	logic aborted;
	logic [DATA_W-1:0] const_bank [CONST_COUNT];

	// Block base is aligned, so the counter fills the low bits
	assign al_addr = {PARAM_BLOCK_BASE[FLASH_ADDR_W-1:CNT_W], al_cnt};
	assign al_cmd_data = READ_ARRAY_CMD;
	assign al_op = OP_READ;

	//////////////////////////////
	// Load status
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			al_status <= 3'b000;
		end else if (aborted) begin
			al_status <= 3'b000;
			al_status[ST_ABORTED] <= 1'b1;
		end else if (completed) begin
			al_status <= 3'b000;
			al_status[ST_COMPLETED] <= 1'b1;
		end else if (start && !al_status[ST_RUNNING]) begin
			al_status <= 3'b000;
			al_status[ST_RUNNING] <= 1'b1;
		end
	end

	// Constant bank, old words survive an abort
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			for (int i = 0; i < CONST_COUNT; i++) begin
				const_bank[i] <= '0;
			end
		end else if (rd_valid && al_ena && (al_cnt < CNT_W'(CONST_COUNT))) begin
			const_bank[al_cnt] <= rd_data;
		end
	end

	assign const_data = (const_idx < CNT_W'(CONST_COUNT)) ? const_bank[const_idx] : '0;

	auto_load_fsm u_fsm (
		.CLK       (CLK),
		.RST       (RST),
		.start     (start),
		.busy      (busy),
		.rd_valid  (rd_valid),
		.al_cnt    (al_cnt),
		.execute   (execute),
		.al_ena    (al_ena),
		.completed (completed),
		.aborted   (aborted),
		.seq_abort (seq_abort)
	);

endmodule

// File: bpi_sequencer.sv
`timescale 1ns/10ps

module bpi_sequencer (
	input  logic CLK,
	input  logic RST,
	input  logic execute,
	input  logic abort,
	input  alc_pkg::bpi_op_e op,
	input  logic [alc_pkg::FLASH_ADDR_W-1:0] addr,
	input  logic [alc_pkg::DATA_W-1:0] cmd_data,
	output logic busy,
	output logic rd_valid,
	output logic [alc_pkg::DATA_W-1:0] rd_data,
	output logic [alc_pkg::FLASH_ADDR_W-1:0] flash_addr,
	output logic [alc_pkg::DATA_W-1:0] flash_dq_out,
	output logic flash_dq_oe,
	input  logic [alc_pkg::DATA_W-1:0] flash_dq_in,
	output logic flash_ce_n,
	output logic flash_oe_n,
	output logic flash_we_n,
	input  logic flash_rdy
);
	import alc_pkg::*;

	typedef enum logic [1:0] {SQ_IDLE, SQ_CMD, SQ_GAP, SQ_READ} sq_state_e;

	sq_state_e state;
	logic [CMD_CNT_W-1:0] cmd_cnt;
	logic start_rd;
	logic capture;

	// NOP requests fall through here and never leave idle
	assign start_rd = (state == SQ_IDLE) && execute && (op == OP_READ) && !abort;
	assign capture = (state == SQ_READ) && flash_rdy && !abort;

	//////////////////////////////
	// Strobe sequencing
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			state <= SQ_IDLE;
			cmd_cnt <= '0;
			busy <= 1'b0;
			rd_valid <= 1'b0;
			flash_dq_oe <= 1'b0;
			flash_ce_n <= 1'b1;
			flash_oe_n <= 1'b1;
			flash_we_n <= 1'b1;
		end else if (abort) begin
			state <= SQ_IDLE;
			busy <= 1'b0;
			rd_valid <= 1'b0;
			flash_dq_oe <= 1'b0;
			flash_ce_n <= 1'b1;
			flash_oe_n <= 1'b1;
			flash_we_n <= 1'b1;
		end else begin
			rd_valid <= 1'b0;
			case (state)
				SQ_IDLE: begin
					if (start_rd) begin
						// Command write of the read-array code
						state <= SQ_CMD;
						cmd_cnt <= '0;
						busy <= 1'b1;
						flash_ce_n <= 1'b0;
						flash_we_n <= 1'b0;
						flash_dq_oe <= 1'b1;
					end
				end
				SQ_CMD: begin
					if (cmd_cnt == CMD_CNT_W'(CMD_CYCLES - 1)) begin
						state <= SQ_GAP;
						flash_we_n <= 1'b1;
					end else begin
						cmd_cnt <= cmd_cnt + 1'b1;
					end
				end
				SQ_GAP: begin
					state <= SQ_READ;
					flash_dq_oe <= 1'b0;
					flash_oe_n <= 1'b0;
				end
				SQ_READ: begin
					if (capture) begin
						state <= SQ_IDLE;
						busy <= 1'b0;
						rd_valid <= 1'b1;
						flash_oe_n <= 1'b1;
						flash_ce_n <= 1'b1;
					end
				end
				default: state <= SQ_IDLE;
			endcase
		end
	end

	// Address and data held for the whole operation
	always_ff @(posedge CLK) begin
		if (start_rd) begin
			flash_addr <= addr;
			flash_dq_out <= cmd_data;
		end
		if (capture) begin
			rd_data <= flash_dq_in;
		end
	end

endmodule

// File: axi_lite_regs.sv
`timescale 1ns/10ps

module axi_lite_regs (
	input  logic CLK,
	input  logic RST,
	input  logic [alc_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [alc_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic load_start,
	input  logic [2:0] al_status,
	input  logic [alc_pkg::CNT_W-1:0] al_cnt,
	output logic [alc_pkg::CNT_W-1:0] const_idx,
	input  logic [alc_pkg::DATA_W-1:0] const_data
);
	import alc_pkg::*;

	logic idle;
	logic wr_pair;
	logic wr_go;
	logic rd_go;
	logic wr_mapped;
	logic rd_mapped;
	logic [31:0] rd_word;
	logic [AXI_ADDR_W-1:0] const_off;

	// Word aligned and inside the constant window
	function automatic logic in_const_win(input logic [AXI_ADDR_W-1:0] a);
		return (a >= REG_CONST_BASE) && (a[1:0] == 2'b00)
			&& (int'(a) < int'(REG_CONST_BASE) + 4 * CONST_COUNT);
	endfunction

	//////////////////////////////
	// Handshake, one transaction at a time
	assign idle = !bvalid && !rvalid;
	assign wr_pair = awvalid && wvalid;
	assign wr_go = idle && wr_pair;
	// Writes win when both arrive together
	assign rd_go = idle && arvalid && !wr_pair;
	assign awready = idle && wvalid;
	assign wready = idle && awvalid;
	assign arready = rd_go;

	assign const_off = araddr - REG_CONST_BASE;
	assign const_idx = const_off[CNT_W+1:2];

	assign wr_mapped = (awaddr == REG_CTRL) || (awaddr == REG_STATUS)
		|| (awaddr == REG_COUNT) || in_const_win(awaddr);

	// Read mux
	always_comb begin
		rd_word = '0;
		rd_mapped = 1'b1;
		if (araddr == REG_CTRL) begin
			rd_word = '0;
		end else if (araddr == REG_STATUS) begin
			rd_word = 32'(al_status);
		end else if (araddr == REG_COUNT) begin
			rd_word = 32'(al_cnt);
		end else if (in_const_win(araddr)) begin
			rd_word = 32'(const_data);
		end else begin
			rd_mapped = 1'b0;
		end
	end

	// Write response and start pulse
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			load_start <= 1'b0;
		end else begin
			load_start <= wr_go && (awaddr == REG_CTRL) && wstrb[0] && wdata[0];
			if (wr_go) begin
				bvalid <= 1'b1;
				bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Read response
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			rvalid <= 1'b0;
			rresp <= RESP_OKAY;
		end else if (rd_go) begin
			rvalid <= 1'b1;
			rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_go) begin
			rdata <= rd_word;
		end
	end

endmodule

// File: alc_top.sv
`timescale 1ns/10ps

module alc_top (
	input  logic CLK,
	input  logic RST,
	input  logic [alc_pkg::AXI_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [alc_pkg::AXI_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  logic rready,
	output logic [alc_pkg::FLASH_ADDR_W-1:0] flash_addr,
	output logic [alc_pkg::DATA_W-1:0] flash_dq_out,
	output logic flash_dq_oe,
	input  logic [alc_pkg::DATA_W-1:0] flash_dq_in,
	output logic flash_ce_n,
	output logic flash_oe_n,
	output logic flash_we_n,
	input  logic flash_rdy
);
	import alc_pkg::*;

	logic load_start;
	logic [2:0] al_status;
	logic [CNT_W-1:0] al_cnt;
	logic [CNT_W-1:0] const_idx;
	logic [DATA_W-1:0] const_data;
	logic [FLASH_ADDR_W-1:0] al_addr;
	logic [DATA_W-1:0] al_cmd_data;
	bpi_op_e al_op;
	logic execute;
	logic seq_abort;
	logic busy;
	logic rd_valid;
	logic [DATA_W-1:0] rd_data;

	//////////////////////////////
	// Host side
	axi_lite_regs u_regs (
		.CLK        (CLK),
		.RST        (RST),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.load_start (load_start),
		.al_status  (al_status),
		.al_cnt     (al_cnt),
		.const_idx  (const_idx),
		.const_data (const_data)
	);

	auto_load_const u_auto_load (
		.CLK         (CLK),
		.RST         (RST),
		.start       (load_start),
		.busy        (busy),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data),
		.const_idx   (const_idx),
		.al_addr     (al_addr),
		.al_cmd_data (al_cmd_data),
		.al_op       (al_op),
		.execute     (execute),
		.seq_abort   (seq_abort),
		.al_status   (al_status),
		.al_cnt      (al_cnt),
		.const_data  (const_data)
	);

	//////////////////////////////
	// Flash side
	bpi_sequencer u_bpi (
		.CLK          (CLK),
		.RST          (RST),
		.execute      (execute),
		.abort        (seq_abort),
		.op           (al_op),
		.addr         (al_addr),
		.cmd_data     (al_cmd_data),
		.busy         (busy),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.flash_addr   (flash_addr),
		.flash_dq_out (flash_dq_out),
		.flash_dq_oe  (flash_dq_oe),
		.flash_dq_in  (flash_dq_in),
		.flash_ce_n   (flash_ce_n),
		.flash_oe_n   (flash_oe_n),
		.flash_we_n   (flash_we_n),
		.flash_rdy    (flash_rdy)
	);

endmodule

// File: bpi_flash_model.sv
`timescale 1ns/10ps

module bpi_flash_model (
	input  logic CLK,
	input  logic RST,
	input  logic [alc_pkg::FLASH_ADDR_W-1:0] flash_addr,
	input  logic [alc_pkg::DATA_W-1:0] flash_dq_out,
	input  logic flash_dq_oe,
	output logic [alc_pkg::DATA_W-1:0] flash_dq_in,
	input  logic flash_ce_n,
	input  logic flash_oe_n,
	input  logic flash_we_n,
	output logic flash_rdy,
	input  logic stall
);
	import alc_pkg::*;

	// Parameter block only, low address bits pick the word
	logic [DATA_W-1:0] mem [64];
	logic read_mode;
	logic we_n_q;
	int unsigned wait_cnt;
	int unsigned delay;

	assign flash_dq_in = (read_mode && !flash_ce_n && !flash_oe_n) ? mem[flash_addr[5:0]] : '0;

	// Command latched when the write strobe rises
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			read_mode <= 1'b0;
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= flash_we_n;
			if (flash_we_n && !we_n_q && !flash_ce_n && flash_dq_oe) begin
				read_mode <= (flash_dq_out == READ_ARRAY_CMD);
			end
		end
	end

	//////////////////////////////
	// Ready after a random access time
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			flash_rdy <= 1'b0;
			wait_cnt <= 0;
			delay <= 0;
		end else if (flash_oe_n || flash_ce_n) begin
			flash_rdy <= 1'b0;
			wait_cnt <= 0;
			delay <= $urandom_range(5, 0);
		end else if (!flash_rdy && !stall) begin
			if (wait_cnt >= delay) begin
				flash_rdy <= 1'b1;
			end else begin
				wait_cnt <= wait_cnt + 1;
			end
		end
	end

endmodule

// File: alc_chk.sv
`timescale 1ns/10ps

module alc_chk (
	input  logic CLK,
	input  logic RST,
	input  logic [31:0] rdata,
	input  logic bvalid,
	input  logic bready,
	input  logic rvalid,
	input  logic rready,
	input  logic [alc_pkg::FLASH_ADDR_W-1:0] flash_addr,
	input  logic flash_dq_oe,
	input  logic flash_ce_n,
	input  logic flash_oe_n,
	input  logic flash_we_n
);

	int fail_count = 0;

	//////////////////////////////
	// Flash pins
	a_strobe_overlap: assert property (@(posedge CLK) disable iff (RST)
		flash_we_n || flash_oe_n)
		else begin
			$error("write enable and output enable low together");
			fail_count++;
		end

	// No drive from both sides of the data bus
	a_bus_turn: assert property (@(posedge CLK) disable iff (RST)
		!flash_oe_n |-> !flash_dq_oe)
		else begin
			$error("data bus driven while the flash outputs are on");
			fail_count++;
		end

	a_addr_stable: assert property (@(posedge CLK) disable iff (RST)
		!flash_ce_n |=> flash_ce_n || $stable(flash_addr))
		else begin
			$error("flash address moved during an access");
			fail_count++;
		end

	//////////////////////////////
	// AXI responses held until taken
	a_bvalid_hold: assert property (@(posedge CLK) disable iff (RST)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped without bready");
			fail_count++;
		end

	a_rvalid_hold: assert property (@(posedge CLK) disable iff (RST)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			$error("rvalid or rdata changed without rready");
			fail_count++;
		end

endmodule

// File: alc_tb.sv
`timescale 1ns/10ps

module alc_tb;
	import alc_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int SEED = 32'h11bf092d;
	localparam int NUM_LOADS = 4;
	localparam int AXI_CYCLES = 8000;
	localparam int WATCHDOG_CYCLES = NUM_LOADS * CONST_COUNT * (RD_TIMEOUT + 10) + AXI_CYCLES;
	localparam int NO_STALL = 99;
	localparam logic [2:0] STAT_DONE = 3'b001 << ST_COMPLETED;
	localparam logic [2:0] STAT_ABORT = 3'b001 << ST_ABORTED;

	logic CLK;
	logic RST;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [FLASH_ADDR_W-1:0] flash_addr;
	logic [DATA_W-1:0] flash_dq_out;
	logic flash_dq_oe;
	logic [DATA_W-1:0] flash_dq_in;
	logic flash_ce_n;
	logic flash_oe_n;
	logic flash_we_n;
	logic flash_rdy;
	logic stall;

	// Expected state of the design
	logic [DATA_W-1:0] flash_words [64];
	logic [DATA_W-1:0] exp_bank [CONST_COUNT];
	logic [2:0] exp_status;
	logic [CNT_W-1:0] exp_count;
	int cmds_seen;
	int reads_seen;
	int stall_at;
	logic cmd_open;
	logic we_n_prev;

	alc_top dut (.*);
	bpi_flash_model u_flash (.*);
	bind alc_top alc_chk u_chk (.*);

	// Flash holds off ready on the chosen word
	assign stall = (reads_seen == stall_at);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$fatal(1, "timeout");
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped on first error");
	endtask

	always @(dut.u_chk.fail_count) begin
		if (dut.u_chk.fail_count != 0) begin
			stop_with_failure("assertion on the flash pins or the AXI handshake failed");
		end
	end

	//////////////////////////////
	// Compare tasks
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_status(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input logic [FLASH_ADDR_W-1:0] got,
			input logic [FLASH_ADDR_W-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	//////////////////////////////
	// AXI master
	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int delay;
		delay = $urandom_range(4, 0);
		@(negedge CLK);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		// Idle slave takes address and data on the next edge
		@(posedge CLK);
		if (!awready || !wready) begin
			stop_with_failure("idle slave did not accept the write address and data");
		end
		@(negedge CLK);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!bvalid) begin
			stop_with_failure("write response missing one cycle after acceptance");
		end
		resp = bresp;
		repeat (delay) begin
			@(negedge CLK);
			if (!bvalid) stop_with_failure("write response dropped before bready");
		end
		bready = 1'b1;
		@(negedge CLK);
		bready = 1'b0;
		if (bvalid) stop_with_failure("write response repeated after bready");
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int delay;
		delay = $urandom_range(4, 0);
		@(negedge CLK);
		araddr = addr;
		arvalid = 1'b1;
		@(posedge CLK);
		if (!arready) begin
			stop_with_failure("idle slave did not accept the read address");
		end
		@(negedge CLK);
		arvalid = 1'b0;
		if (!rvalid) begin
			stop_with_failure("read response missing one cycle after acceptance");
		end
		data = rdata;
		resp = rresp;
		repeat (delay) begin
			@(negedge CLK);
			if (!rvalid) stop_with_failure("read response dropped before rready");
		end
		rready = 1'b1;
		@(negedge CLK);
		rready = 1'b0;
		if (rvalid) stop_with_failure("read response repeated after rready");
	endtask

	task automatic read_okay(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_resp("rresp", resp, RESP_OKAY);
	endtask

	function automatic logic is_mapped(input logic [AXI_ADDR_W-1:0] a);
		if (a == REG_CTRL || a == REG_STATUS || a == REG_COUNT) return 1'b1;
		return a >= REG_CONST_BASE && a[1:0] == 2'b00 && (a - REG_CONST_BASE) < 4 * CONST_COUNT;
	endfunction

	function automatic logic [31:0] expected_read(input logic [AXI_ADDR_W-1:0] a);
		if (a == REG_STATUS) return 32'(exp_status);
		if (a == REG_COUNT) return 32'(exp_count);
		if (a >= REG_CONST_BASE && is_mapped(a)) return 32'(exp_bank[(a - REG_CONST_BASE) >> 2]);
		return 32'h0;
	endfunction

	//////////////////////////////
	// Flash pin monitor
	always @(negedge CLK) begin
		if (!RST) begin
			if (!flash_we_n && we_n_prev) begin
				if (cmds_seen >= CONST_COUNT) stop_with_failure("flash command after the last word");
				check_word("flash_dq_out", 32'(flash_dq_out), 32'(READ_ARRAY_CMD));
				check_addr("flash_addr", flash_addr, PARAM_BLOCK_BASE + FLASH_ADDR_W'(cmds_seen));
				cmds_seen++;
				cmd_open = 1'b1;
			end
			if (!flash_oe_n && flash_rdy) begin
				if (!cmd_open) stop_with_failure("flash read without a command write before it");
				check_addr("flash_addr", flash_addr, PARAM_BLOCK_BASE + FLASH_ADDR_W'(reads_seen));
				reads_seen++;
				cmd_open = 1'b0;
			end
		end
		we_n_prev = flash_we_n;
	end

	task automatic fill_flash();
		for (int i = 0; i < 64; i++) begin
			flash_words[i] = DATA_W'($urandom);
			u_flash.mem[i] = flash_words[i];
		end
	endtask

	task automatic check_registers();
		logic [31:0] data;
		read_okay(REG_STATUS, data);
		check_status("STATUS", data[2:0], exp_status);
		read_okay(REG_COUNT, data);
		check_word("COUNT", data, 32'(exp_count));
		for (int i = 0; i < CONST_COUNT; i++) begin
			read_okay(REG_CONST_BASE + AXI_ADDR_W'(4 * i), data);
			check_word($sformatf("const[%0d]", i), data, 32'(exp_bank[i]));
		end
	endtask

	task automatic start_load();
		logic [1:0] resp;
		cmds_seen = 0;
		reads_seen = 0;
		cmd_open = 1'b0;
		axi_write(REG_CTRL, 32'h1, resp);
		check_resp("bresp", resp, RESP_OKAY);
	endtask

	task automatic wait_load_end(output logic [2:0] st);
		logic [31:0] data;
		do read_okay(REG_STATUS, data); while (data[ST_RUNNING]);
		st = data[2:0];
	endtask

	task automatic expect_completed(input logic [2:0] st);
		check_status("STATUS", st, STAT_DONE);
		if (reads_seen != CONST_COUNT || cmds_seen != CONST_COUNT) begin
			stop_with_failure($sformatf("load made %0d commands and %0d reads instead of %0d",
				cmds_seen, reads_seen, CONST_COUNT));
		end
		for (int i = 0; i < CONST_COUNT; i++) begin
			exp_bank[i] = flash_words[i];
		end
		exp_status = STAT_DONE;
		exp_count = CNT_W'(CONST_COUNT);
		check_registers();
	endtask

	task automatic random_axi_traffic(input int n);
		logic [AXI_ADDR_W-1:0] addr;
		logic [31:0] data;
		logic [1:0] resp;
		for (int i = 0; i < n; i++) begin
			addr = AXI_ADDR_W'($urandom);
			if ($urandom_range(1, 0) == 1) begin
				axi_read(addr, data, resp);
				check_resp("rresp", resp, is_mapped(addr) ? RESP_OKAY : RESP_SLVERR);
				if (is_mapped(addr)) check_word("rdata", data, expected_read(addr));
			end else begin
				// Bit 0 low so that CTRL never starts a load here
				axi_write(addr, $urandom & 32'hFFFF_FFFE, resp);
				check_resp("bresp", resp, is_mapped(addr) ? RESP_OKAY : RESP_SLVERR);
			end
		end
	endtask

	initial begin
		int k;
		logic [2:0] st;
		logic [31:0] data;
		logic [1:0] resp;
		void'($urandom(SEED));
		RST = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		stall_at = NO_STALL;
		cmds_seen = 0;
		reads_seen = 0;
		cmd_open = 1'b0;
		we_n_prev = 1'b1;
		exp_status = '0;
		exp_count = '0;
		for (int i = 0; i < CONST_COUNT; i++) begin
			exp_bank[i] = '0;
		end
		fill_flash();
		repeat (16) @(negedge CLK);
		RST = 1'b0;
		check_registers();

		// Full load from power-up state
		start_load();
		wait_load_end(st);
		expect_completed(st);

		// Read-only registers and unmapped space
		axi_write(REG_STATUS, 32'hFFFF_FFFF, resp);
		check_resp("bresp", resp, RESP_OKAY);
		axi_write(REG_COUNT, 32'hFFFF_FFFF, resp);
		check_resp("bresp", resp, RESP_OKAY);
		axi_write(8'h0C, 32'h1, resp);
		check_resp("bresp", resp, RESP_SLVERR);
		axi_read(8'hFC, data, resp);
		check_resp("rresp", resp, RESP_SLVERR);
		random_axi_traffic(40);
		check_registers();

		// Stalled word ends in an abort
		k = $urandom_range(CONST_COUNT - 1, 1);
		fill_flash();
		stall_at = k;
		start_load();
		wait_load_end(st);
		check_status("STATUS", st, STAT_ABORT);
		if (reads_seen != k) stop_with_failure("abort did not stop on the stalled word");
		for (int i = 0; i < k; i++) begin
			exp_bank[i] = flash_words[i];
		end
		exp_status = STAT_ABORT;
		exp_count = CNT_W'(k);
		check_registers();
		stall_at = NO_STALL;
		fill_flash();
		start_load();
		wait_load_end(st);
		expect_completed(st);

		// Second start in the middle of a load
		fill_flash();
		start_load();
		wait (reads_seen >= CONST_COUNT / 3);
		axi_write(REG_CTRL, 32'h1, resp);
		check_resp("bresp", resp, RESP_OKAY);
		wait_load_end(st);
		expect_completed(st);

		if (dut.u_chk.fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: all.f
alc_pkg.sv
auto_load_fsm.sv
auto_load_const.sv
bpi_sequencer.sv
axi_lite_regs.sv
alc_top.sv
bpi_flash_model.sv
alc_chk.sv
alc_tb.sv

// File: Bender.yml
package:
  name: alc

sources:
  - alc_pkg.sv
  - auto_load_fsm.sv
  - auto_load_const.sv
  - bpi_sequencer.sv
  - axi_lite_regs.sv
  - alc_top.sv
  - target: test
    files:
      - bpi_flash_model.sv
      - alc_chk.sv
      - alc_tb.sv
